// File: bench/clockGen.sv
`default_nettype none

module clockGen #(
	parameter int period = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(period / 2) clk = ~clk; // Rising edges at odd multiples of half a period

endmodule

`default_nettype wire

// File: bench/timeOverlayTb.sv
`default_nettype none

module timeOverlayTb;

	// Glyph geometry passed to the DUT parameters
	localparam int originX = 200;
	localparam int originY = 340;
	localparam int blockSize = 5;
	localparam int digitGap = 20;

	localparam int streamPixels = 1000;
	localparam int stallPixels = 3000;
	localparam int numPixels = streamPixels + stallPixels;
	// Worst case about 3 cycles per pixel plus drain margin
	localparam int timeoutCycles = numPixels * 5;

	// One-hot segment bits in segT order
	localparam logic [6:0] topSeg = 7'b1000000;
	localparam logic [6:0] upperRightSeg = 7'b0100000;
	localparam logic [6:0] lowerRightSeg = 7'b0010000;
	localparam logic [6:0] bottomSeg = 7'b0001000;
	localparam logic [6:0] lowerLeftSeg = 7'b0000100;
	localparam logic [6:0] upperLeftSeg = 7'b0000010;
	localparam logic [6:0] middleSeg = 7'b0000001;
	localparam logic [6:0] allSegs = 7'b1111111;

	logic clk;
	logic rstN;
	logic inValid;
	videoPixelPkg::pixelReqT inPixel;
	logic inReady;
	logic outValid;
	videoPixelPkg::rgbT outColor;
	logic outReady;

	logic [31:0] rngState = 32'h800b_8861;
	int cycleCount = 0;
	int outputsSeen = 0;
	int colorCount[8];
	logic streamPhase = 1'b0;

	logic [2:0] expectedQ[$];
	int acceptCycleQ[$];
	logic strictQ[$]; // Latency is exact only for streamed pixels

	clockGen #(.period(4)) clock (.clk(clk));

	timeOverlay #(
		.originX(originX),
		.originY(originY),
		.blockSize(blockSize),
		.digitGap(digitGap)
	) UUT (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inPixel(inPixel),
		.inReady(inReady),
		.outValid(outValid),
		.outColor(outColor),
		.outReady(outReady)
	);

	// LCG step
	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic int randRange(input int lo, input int hi);
		return lo + int'(nextRandom() >> 8) % (hi - lo + 1); // Upper bits are the better ones
	endfunction

	function automatic clockGeomPkg::bcdT randomDigit();
		if (randRange(0, 7) == 0) begin
			return clockGeomPkg::bcdT'(randRange(10, 15));
		end else begin
			return clockGeomPkg::bcdT'(randRange(0, 9));
		end
	endfunction

	function automatic videoPixelPkg::pixelReqT randomPixel();
		videoPixelPkg::pixelReqT p;
		if (randRange(0, 1) == 0) begin
			p.x = clockGeomPkg::coordT'(randRange(195, 390)); // Glyph region
			p.y = clockGeomPkg::coordT'(randRange(335, 390));
		end else begin
			p.x = clockGeomPkg::coordT'(randRange(0, 799));
			p.y = clockGeomPkg::coordT'(randRange(0, 599));
		end
		p.curTime.h1 = randomDigit();
		p.curTime.h0 = randomDigit();
		p.curTime.m1 = randomDigit();
		p.curTime.m0 = randomDigit();
		p.curTime.s1 = randomDigit();
		p.curTime.s0 = randomDigit();
		return p;
	endfunction

	function automatic logic [6:0] segmentsFor(input logic [3:0] d);
		case (d)
			4'd0: return allSegs & ~middleSeg;
			4'd1: return upperRightSeg | lowerRightSeg;
			4'd2: return topSeg | upperRightSeg | middleSeg | lowerLeftSeg | bottomSeg;
			4'd3: return topSeg | upperRightSeg | middleSeg | lowerRightSeg | bottomSeg;
			4'd4: return upperLeftSeg | upperRightSeg | middleSeg | lowerRightSeg;
			4'd5: return topSeg | upperLeftSeg | middleSeg | lowerRightSeg | bottomSeg;
			4'd6: return allSegs & ~upperRightSeg;
			4'd7: return topSeg | upperRightSeg | lowerRightSeg;
			4'd8: return allSegs;
			4'd9: return allSegs & ~lowerLeftSeg;
			default: return 7'b0000000; // Blank codes
		endcase
	endfunction

	function automatic logic inSegment(input int x, input int y, input int cellX, input int s);
		logic [15:0] box; // First column, last column, first row, last row
		case (s)
			6: box = {4'd1, 4'd4, 4'd0, 4'd1}; // Top
			5: box = {4'd4, 4'd5, 4'd1, 4'd4};
			4: box = {4'd4, 4'd5, 4'd5, 4'd8};
			3: box = {4'd1, 4'd4, 4'd8, 4'd9}; // Bottom
			2: box = {4'd0, 4'd1, 4'd5, 4'd8};
			1: box = {4'd0, 4'd1, 4'd1, 4'd4};
			default: box = {4'd1, 4'd4, 4'd4, 4'd5}; // Middle
		endcase
		return x >= cellX + int'(box[15:12]) * blockSize
			&& x <= cellX + int'(box[11:8]) * blockSize
			&& y >= originY + int'(box[7:4]) * blockSize
			&& y <= originY + int'(box[3:0]) * blockSize;
	endfunction

	function automatic logic [2:0] modelColor(input int x, input int y, input logic [23:0] t);
		logic lit;
		logic colon;
		logic [6:0] pattern;
		int cellX;
		int colonX;
		int n;
		int s;
		lit = 1'b0;
		colon = 1'b0;
		for (n = 0; n < 6; n++) begin
			cellX = originX + n * (digitGap + 5 * blockSize);
			pattern = segmentsFor(t[23 - 4 * n -: 4]); // n = 0 is h1
			for (s = 0; s < 7; s++) begin
				if (pattern[s] && inSegment(x, y, cellX, s)) begin
					lit = 1'b1;
				end
			end
		end
		for (n = 0; n < 2; n++) begin
			colonX = originX + digitGap + (n == 0 ? 12 : 30) * blockSize;
			if (x >= colonX && x <= colonX + blockSize) begin
				if ((y >= originY + 2 * blockSize && y <= originY + 4 * blockSize)
					|| (y >= originY + 5 * blockSize && y <= originY + 7 * blockSize)) begin
					colon = 1'b1;
				end
			end
		end
		if (colon) begin
			return 3'b101; // Magenta
		end else if (lit) begin
			return 3'b110; // Yellow
		end else begin
			return 3'b001;
		end
	endfunction

	task automatic checkValue(input int got, input int expected, input string what);
		if (got != expected) begin
			$display("ERROR at time %0t: %s, got %0d expected %0d", $time, what, got, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// Sends count pixels, holding each one until it is taken
	task automatic runPhase(input int count, input logic stall, input int gapPercent);
		int sent;
		logic accepted;
		sent = 0;
		while (sent < count) begin
			if (!inValid && randRange(0, 99) >= gapPercent) begin
				inPixel = randomPixel();
				inValid = 1'b1;
			end
			@(negedge clk);
			accepted = inValid && inReady;
			@(posedge clk);
			#1;
			if (accepted) begin
				sent++;
				inValid = 1'b0;
			end
			outReady = stall ? (randRange(0, 99) >= 40) : 1'b1; // About 40% stalled
		end
	endtask

	task automatic drainPipe();
		while (expectedQ.size() != 0) begin
			@(posedge clk);
			#1;
			outReady = 1'b1;
		end
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("Test failed");
			$fatal(1);
		end
	end

	// Handshakes are sampled mid-cycle, where inputs and outputs are settled
	always @(negedge clk) begin
		logic [2:0] expected;
		if (rstN) begin
			if (streamPhase) begin
				checkValue(int'(inReady), 1, "inReady dropped while streaming");
			end
			if (inValid && inReady) begin
				expected = modelColor(int'(inPixel.x), int'(inPixel.y), inPixel.curTime);
				expectedQ.push_back(expected);
				acceptCycleQ.push_back(cycleCount);
				strictQ.push_back(streamPhase);
			end
			if (outValid && outReady) begin
				if (expectedQ.size() == 0) begin
					$display("Output transfer at time %0t with no pixel outstanding", $time);
					$display("Test failed");
					$fatal(1);
				end else begin
					checkValue(int'(outColor), int'(expectedQ[0]), "outColor mismatch");
					if (strictQ[0]) begin
						checkValue(cycleCount - acceptCycleQ[0], 3, "latency in cycles");
					end
					colorCount[outColor]++;
					outputsSeen++;
					void'(expectedQ.pop_front());
					void'(acceptCycleQ.pop_front());
					void'(strictQ.pop_front());
				end
			end
		end
	end

	initial begin
		rstN = 1'b0;
		inValid = 1'b0;
		inPixel = '0;
		outReady = 1'b1;
		for (int i = 0; i < 8; i++) begin
			colorCount[i] = 0;
		end
		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;
		checkValue(int'(outValid), 0, "outValid after reset");
		checkValue(int'(inReady), 1, "inReady after reset");

		// Full throughput, no stalls
		streamPhase = 1'b1;
		runPhase(streamPixels, 1'b0, 0);
		streamPhase = 1'b0;
		drainPipe();

		// Random downstream stalls and input gaps
		runPhase(stallPixels, 1'b1, 25);
		drainPipe();
		repeat (4) @(posedge clk);

		checkValue(outputsSeen, numPixels, "number of output pixels");
		checkValue(int'(colorCount[1] > 0), 1, "no background pixel seen");
		checkValue(int'(colorCount[6] > 0), 1, "no segment pixel seen");
		checkValue(int'(colorCount[5] > 0), 1, "no colon pixel seen");

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hdl/clockGeomPkg.sv
hdl/videoPixelPkg.sv
hdl/segmentDecoder.sv
hdl/pixelIntake.sv
hdl/glyphRaster.sv
hdl/colorShader.sv
hdl/timeOverlay.sv
bench/clockGen.sv
bench/timeOverlayTb.sv

// File: hdl/clockGeomPkg.sv
`default_nettype none

// Geometry and time types for the clock overlay
package clockGeomPkg;

	typedef logic [10:0] coordT; // Screen x or y
	typedef logic [3:0] bcdT; // One time digit
	typedef logic [6:0] segT;

	// Bit positions inside segT
	localparam int segTop = 6;
	localparam int segUpperRight = 5;
	localparam int segLowerRight = 4;
	localparam int segBottom = 3;
	localparam int segLowerLeft = 2;
	localparam int segUpperLeft = 1;
	localparam int segMiddle = 0;

	// h1 is the leftmost digit on screen
	typedef struct packed {
		bcdT h1;
		bcdT h0;
		bcdT m1;
		bcdT m0;
		bcdT s1;
		bcdT s0;
	} clockTimeT;

endpackage

`default_nettype wire

// File: hdl/colorShader.sv
`default_nettype none

module colorShader (
	input wire logic clk,
	input wire logic rstN,

	input wire logic fragValid,
	input wire videoPixelPkg::fragmentT frag,
	output logic fragReady,

	output logic outValid,
	output videoPixelPkg::rgbT outColor,
	input wire logic outReady
);

	videoPixelPkg::rgbT colorNext;

	// Colon wins over a plain lit pixel
	always_comb begin
		if (frag.colon) begin
			colorNext = videoPixelPkg::colorColon;
		end else if (frag.lit) begin
			colorNext = videoPixelPkg::colorSegment;
		end else begin
			colorNext = videoPixelPkg::colorBackground;
		end
	end

	assign fragReady = !outValid || outReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (fragReady) begin
			outValid <= fragValid;
		end
	end

	// Held while downstream stalls
	always_ff @(posedge clk) begin
		if (fragReady && fragValid) begin
			outColor <= colorNext;
		end
	end

endmodule

`default_nettype wire

// File: hdl/glyphRaster.sv
`default_nettype none

module glyphRaster #(
	parameter int originX = 200,
	parameter int originY = 340,
	parameter int blockSize = 5,
	parameter int digitGap = 20
) (
	input wire logic clk,
	input wire logic rstN,

	input wire logic reqValid,
	input wire videoPixelPkg::pixelReqT reqPixel,
	output logic reqReady,

	output logic fragValid,
	output videoPixelPkg::fragmentT frag,
	input wire logic fragReady
);

	localparam int digitPitch = digitGap + 5 * blockSize; // One digit cell plus its gap
	localparam int colonBase = originX + digitGap;

	clockGeomPkg::bcdT [5:0] digits;
	logic [5:0] digitLit;
	logic colonHit;
	videoPixelPkg::fragmentT fragNext;

	// Inclusive box in grid cells, rows counted from originY
	function automatic logic inCells(
		input clockGeomPkg::coordT x,
		input clockGeomPkg::coordT y,
		input int cellX,
		input int c0,
		input int c1,
		input int r0,
		input int r1
	);
		return int'(x) >= cellX + c0 * blockSize && int'(x) <= cellX + c1 * blockSize
			&& int'(y) >= originY + r0 * blockSize && int'(y) <= originY + r1 * blockSize;
	endfunction

	assign digits = reqPixel.curTime; // digits[5] is h1

	for (genvar n = 0; n < 6; n++) begin : digitGen
		localparam int cellX = originX + n * digitPitch;

		clockGeomPkg::segT segments;
		clockGeomPkg::segT inSeg;

		segmentDecoder decoder (
			.digit(digits[5 - n]),
			.segments(segments)
		);

		assign inSeg[clockGeomPkg::segTop] =
			inCells(reqPixel.x, reqPixel.y, cellX, 1, 4, 0, 1);
		assign inSeg[clockGeomPkg::segUpperRight] =
			inCells(reqPixel.x, reqPixel.y, cellX, 4, 5, 1, 4);
		assign inSeg[clockGeomPkg::segLowerRight] =
			inCells(reqPixel.x, reqPixel.y, cellX, 4, 5, 5, 8);
		assign inSeg[clockGeomPkg::segBottom] =
			inCells(reqPixel.x, reqPixel.y, cellX, 1, 4, 8, 9);
		assign inSeg[clockGeomPkg::segLowerLeft] =
			inCells(reqPixel.x, reqPixel.y, cellX, 0, 1, 5, 8);
		assign inSeg[clockGeomPkg::segUpperLeft] =
			inCells(reqPixel.x, reqPixel.y, cellX, 0, 1, 1, 4);
		assign inSeg[clockGeomPkg::segMiddle] =
			inCells(reqPixel.x, reqPixel.y, cellX, 1, 4, 4, 5);

		assign digitLit[n] = |(segments & inSeg); // Only segments the digit lights
	end

	// Two colon columns, each with an upper and a lower dot
	assign colonHit = inCells(reqPixel.x, reqPixel.y, colonBase, 12, 13, 2, 4)
		|| inCells(reqPixel.x, reqPixel.y, colonBase, 12, 13, 5, 7)
		|| inCells(reqPixel.x, reqPixel.y, colonBase, 30, 31, 2, 4)
		|| inCells(reqPixel.x, reqPixel.y, colonBase, 30, 31, 5, 7);

	assign fragNext.lit = |digitLit || colonHit;
	assign fragNext.colon = colonHit;

	assign reqReady = !fragValid || fragReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			fragValid <= 1'b0;
		end else if (reqReady) begin
			fragValid <= reqValid;
		end
	end

	always_ff @(posedge clk) begin
		if (reqReady && reqValid) begin
			frag <= fragNext;
		end
	end

endmodule

`default_nettype wire

// File: hdl/pixelIntake.sv
`default_nettype none

module pixelIntake (
	input wire logic clk,
	input wire logic rstN,

	input wire logic inValid,
	input wire videoPixelPkg::pixelReqT inPixel,
	output logic inReady,

	output logic reqValid,
	output videoPixelPkg::pixelReqT reqPixel,
	input wire logic reqReady
);

	// Free slot, or the held request leaves this cycle
	assign inReady = !reqValid || reqReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			reqValid <= 1'b0;
		end else if (inReady) begin
			reqValid <= inValid;
		end
	end

	// Time is captured with the coordinates so a mid-line change only hits later pixels
	always_ff @(posedge clk) begin
		if (inReady && inValid) begin
			reqPixel <= inPixel;
		end
	end

endmodule

`default_nettype wire

// File: hdl/segmentDecoder.sv
`default_nettype none

module segmentDecoder (
	input wire clockGeomPkg::bcdT digit,
	output clockGeomPkg::segT segments
);

	// Order is top, upper right, lower right, bottom, lower left, upper left, middle
	always_comb begin
		case (digit)
			4'd0: segments = 7'b1111110;
			4'd1: segments = 7'b0110000;
			4'd2: segments = 7'b1101101;
			4'd3: segments = 7'b1111001;
			4'd4: segments = 7'b0110011;
			4'd5: segments = 7'b1011011;
			4'd6: segments = 7'b1011111;
			4'd7: segments = 7'b1110000;
			4'd8: segments = 7'b1111111;
			4'd9: segments = 7'b1111011;
			default: segments = 7'b0000000; // Codes 10 to 15 stay dark
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/timeOverlay.sv
`default_nettype none

module timeOverlay #(
	parameter int originX = 200,
	parameter int originY = 340,
	parameter int blockSize = 5,
	parameter int digitGap = 20
) (
	input wire logic clk,
	input wire logic rstN,

	input wire logic inValid,
	input wire videoPixelPkg::pixelReqT inPixel,
	output logic inReady,

	output logic outValid,
	output videoPixelPkg::rgbT outColor,
	input wire logic outReady
);

	logic reqValid;
	videoPixelPkg::pixelReqT reqPixel;
	logic reqReady;

	logic fragValid;
	videoPixelPkg::fragmentT frag;
	logic fragReady;

	pixelIntake intake (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inPixel(inPixel),
		.inReady(inReady),
		.reqValid(reqValid),
		.reqPixel(reqPixel),
		.reqReady(reqReady)
	);

	// Only the raster stage needs the glyph geometry
	glyphRaster #(
		.originX(originX),
		.originY(originY),
		.blockSize(blockSize),
		.digitGap(digitGap)
	) raster (
		.clk(clk),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqPixel(reqPixel),
		.reqReady(reqReady),
		.fragValid(fragValid),
		.frag(frag),
		.fragReady(fragReady)
	);

	colorShader shader (
		.clk(clk),
		.rstN(rstN),
		.fragValid(fragValid),
		.frag(frag),
		.fragReady(fragReady),
		.outValid(outValid),
		.outColor(outColor),
		.outReady(outReady)
	);

endmodule

`default_nettype wire

// File: hdl/videoPixelPkg.sv
`default_nettype none

// Pixel stream payloads and colours
package videoPixelPkg;

	// One pixel request, with the time that applies to it
	typedef struct packed {
		clockGeomPkg::coordT x;
		clockGeomPkg::coordT y;
		clockGeomPkg::clockTimeT curTime;
	} pixelReqT;

	typedef struct packed {
		logic lit; // Inside a lit segment or a colon
		logic colon; // Inside a colon dot
	} fragmentT;

	typedef logic [2:0] rgbT; // Red is the MSB

	localparam rgbT colorBackground = 3'b001; // Blue
	localparam rgbT colorSegment = 3'b110; // Yellow
	localparam rgbT colorColon = 3'b101; // Magenta

endpackage

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Build and run the timeOverlay testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -j 0 --top-module timeOverlayTb -f files.f > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/VtimeOverlayTb > sim.log 2>&1

grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
